//--- Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := tb_cpu_core
FILELIST := vlog.f
BUILD    := obj_dir
LOG      := sim.log
RUNFLAGS := +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath and instruction word width
`define DATA_W      32

// general purpose registers, r0 included
`define REG_COUNT   16

////////////////////////////////////////
// instruction fields
////////////////////////////////////////

// opcode in the top nibble
`define OPC_MSB     31
`define OPC_LSB     28
// register indexes, each one index wide
`define RD_LSB      24
`define RS1_LSB     20
`define RS2_LSB     16
// immediate fills the low half of the word
`define IMM_W       16

`endif

//--- core_pkg.sv
package core_pkg;

    // operation the alu performs in execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SHL,
        ALU_SHR
    } alu_op_e;

    // where the retiring result comes from
    typedef enum logic [1:0] {
        RES_ALU,
        RES_IMM,
        RES_SEL
    } res_sel_e;

    // wishbone slave, ack is the registered state
    typedef enum logic {
        BUS_IDLE,
        BUS_ACK
    } bus_state_e;

endpackage

//--- cpu_core.sv
`timescale 1ns/100ps

module cpu_core (
    input  logic                clk,
    input  logic                rst_n,
    // wishbone classic slave, instruction writes
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  isa_pkg::word_t      dat_w,
    output logic                ack,
    // retire and flag observation
    output logic                retire_valid,
    output logic                retire_wen,
    output isa_pkg::reg_idx_t   retire_rd,
    output isa_pkg::word_t      retire_data,
    output isa_pkg::flags_t     flags
);

    import isa_pkg::*;
    import core_pkg::*;

    // register file reads
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;

    // decode to execute
    logic     de_valid;
    alu_op_e  de_op;
    res_sel_e de_sel;
    logic     de_wen;
    logic     de_set_flags;
    reg_idx_t de_rd;
    word_t    de_a;
    word_t    de_b;
    word_t    de_imm;

    ////////////////////////////////////////
    // pipeline stages
    ////////////////////////////////////////

    decode_stage i_decode (
        .clk(clk),
        .rst_n(rst_n),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .dat_w(dat_w),
        .ack(ack),
        .rs1_idx(rs1_idx),
        .rs2_idx(rs2_idx),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .de_valid(de_valid),
        .de_op(de_op),
        .de_sel(de_sel),
        .de_wen(de_wen),
        .de_set_flags(de_set_flags),
        .de_rd(de_rd),
        .de_a(de_a),
        .de_b(de_b),
        .de_imm(de_imm)
    );

    execute_stage i_execute (
        .clk(clk),
        .rst_n(rst_n),
        .de_valid(de_valid),
        .de_op(de_op),
        .de_sel(de_sel),
        .de_wen(de_wen),
        .de_set_flags(de_set_flags),
        .de_rd(de_rd),
        .de_a(de_a),
        .de_b(de_b),
        .de_imm(de_imm),
        .retire_valid(retire_valid),
        .retire_wen(retire_wen),
        .retire_rd(retire_rd),
        .retire_data(retire_data),
        .flags(flags)
    );

    // retire feeds both the array and the bypass
    result_stage i_result (
        .clk(clk),
        .rst_n(rst_n),
        .rs1_idx(rs1_idx),
        .rs2_idx(rs2_idx),
        .retire_valid(retire_valid),
        .retire_wen(retire_wen),
        .retire_rd(retire_rd),
        .retire_data(retire_data),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

endmodule

//--- cpu_core_properties.sv
`timescale 1ns/100ps

module cpu_core_properties (
    input logic clk,
    input logic rst_n,
    input logic cyc,
    input logic stb,
    input logic we,
    input logic ack,
    input logic retire_valid
);

    // failed checks so far
    int assert_fails = 0;

    ////////////////////////////////////////
    // bus handshake
    ////////////////////////////////////////

    // ack is a one cycle pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
        else begin
            assert_fails++;
            $error("ack stayed high for more than one cycle");
        end

    ////////////////////////////////////////
    // retire timing
    ////////////////////////////////////////

    // accepted write, ack one edge later, retire two after that
    write_retires: assert property (@(posedge clk) disable iff (!rst_n)
        $past(cyc && stb && we && !ack, 3) |-> $rose(retire_valid))
        else begin
            assert_fails++;
            $error("retire_valid did not rise two cycles after ack of a write");
        end

    // no retire without an ack two cycles before
    retire_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(retire_valid) |-> $past(ack, 2))
        else begin
            assert_fails++;
            $error("retire_valid rose without an ack two cycles earlier");
        end

    // read cycles never reach execute
    read_no_retire: assert property (@(posedge clk) disable iff (!rst_n)
        $past(cyc && stb && !we && !ack, 3) |-> !retire_valid)
        else begin
            assert_fails++;
            $error("a read cycle produced a retire");
        end

    // quiet in the first cycle after reset
    reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !ack && !retire_valid)
        else begin
            assert_fails++;
            $error("ack or retire_valid high right after reset");
        end

endmodule

//--- decode_stage.sv
`timescale 1ns/100ps
`include "core_params.svh"

module decode_stage (
    input  logic                clk,
    input  logic                rst_n,
    // wishbone classic slave
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  isa_pkg::word_t      dat_w,
    output logic                ack,
    // register file read ports
    output isa_pkg::reg_idx_t   rs1_idx,
    output isa_pkg::reg_idx_t   rs2_idx,
    input  isa_pkg::word_t      rs1_data,
    input  isa_pkg::word_t      rs2_data,
    // decoded instruction to execute
    output logic                de_valid,
    output core_pkg::alu_op_e   de_op,
    output core_pkg::res_sel_e  de_sel,
    output logic                de_wen,
    output logic                de_set_flags,
    output isa_pkg::reg_idx_t   de_rd,
    output isa_pkg::word_t      de_a,
    output isa_pkg::word_t      de_b,
    output isa_pkg::word_t      de_imm
);

    import isa_pkg::*;
    import core_pkg::*;

    bus_state_e state;
    logic       accept;
    word_t      ir;
    logic       ir_valid;

    opcode_e    opc;
    word_t      imm_sext;
    alu_op_e    dec_op;
    res_sel_e   dec_sel;
    logic       dec_wen;
    logic       dec_set_flags;
    logic       dec_use_imm;

    ////////////////////////////////////////
    // bus slave
    ////////////////////////////////////////

    // a transfer starts only while ack is low
    assign accept = cyc && stb && (state == BUS_IDLE);
    assign ack    = (state == BUS_ACK);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= BUS_IDLE;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (accept) begin
                        state <= BUS_ACK;
                    end
                end
                // one cycle of ack, then back to idle
                default: begin
                    state <= BUS_IDLE;
                end
            endcase
        end
    end

    // read cycles get acked but never enter the pipe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir_valid <= 1'b0;
        end else begin
            ir_valid <= accept && we;
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (accept && we) begin
            ir <= dat_w;
        end
    end

    ////////////////////////////////////////
    // field slicing and decode
    ////////////////////////////////////////

    assign opc      = opcode_e'(ir[`OPC_MSB:`OPC_LSB]);
    assign rs1_idx  = ir[`RS1_LSB +: $bits(reg_idx_t)];
    assign rs2_idx  = ir[`RS2_LSB +: $bits(reg_idx_t)];
    assign imm_sext = {{(`DATA_W-`IMM_W){ir[`IMM_W-1]}}, ir[`IMM_W-1:0]};

    // opcode to alu operation
    always_comb begin
        case (opc)
            SUB, CMP: dec_op = ALU_SUB;
            AND:      dec_op = ALU_AND;
            OR:       dec_op = ALU_OR;
            XOR:      dec_op = ALU_XOR;
            SHL:      dec_op = ALU_SHL;
            SHR:      dec_op = ALU_SHR;
            default:  dec_op = ALU_ADD;
        endcase
    end

    // result source, write enable, flag enable
    always_comb begin
        dec_sel       = RES_ALU;
        dec_wen       = 1'b0;
        dec_set_flags = 1'b0;
        dec_use_imm   = 1'b0;
        case (opc)
            ADD, SUB, AND, OR, XOR, SHL, SHR: begin
                dec_wen       = 1'b1;
                dec_set_flags = 1'b1;
            end
            ADDI: begin
                dec_wen       = 1'b1;
                dec_set_flags = 1'b1;
                dec_use_imm   = 1'b1;
            end
            LDI: begin
                dec_sel = RES_IMM;
                dec_wen = 1'b1;
            end
            // compare only touches flags
            CMP: begin
                dec_set_flags = 1'b1;
            end
            SELZ: begin
                dec_sel = RES_SEL;
                dec_wen = 1'b1;
            end
            // nop and opcodes 12..15
            default: begin
                dec_sel = RES_ALU;
            end
        endcase
    end

    ////////////////////////////////////////
    // decode to execute register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de_valid     <= 1'b0;
            de_wen       <= 1'b0;
            de_set_flags <= 1'b0;
        end else begin
            de_valid     <= ir_valid;
            de_wen       <= dec_wen;
            de_set_flags <= dec_set_flags;
        end
    end

    // operands come through the result stage bypass
    always_ff @(posedge clk) begin
        de_op  <= dec_op;
        de_sel <= dec_sel;
        de_rd  <= ir[`RD_LSB +: $bits(reg_idx_t)];
        de_a   <= rs1_data;
        de_b   <= dec_use_imm ? imm_sext : rs2_data;
        de_imm <= imm_sext;
    end

endmodule

//--- execute_stage.sv
`timescale 1ns/100ps
`include "core_params.svh"

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    // from decode
    input  logic                de_valid,
    input  core_pkg::alu_op_e   de_op,
    input  core_pkg::res_sel_e  de_sel,
    input  logic                de_wen,
    input  logic                de_set_flags,
    input  isa_pkg::reg_idx_t   de_rd,
    input  isa_pkg::word_t      de_a,
    input  isa_pkg::word_t      de_b,
    input  isa_pkg::word_t      de_imm,
    // retiring result
    output logic                retire_valid,
    output logic                retire_wen,
    output isa_pkg::reg_idx_t   retire_rd,
    output isa_pkg::word_t      retire_data,
    output isa_pkg::flags_t     flags
);

    import isa_pkg::*;
    import core_pkg::*;

    word_t  alu_res;
    word_t  result;
    flags_t alu_flags;

    ////////////////////////////////////////
    // alu
    ////////////////////////////////////////

    // shifts use only the low bits of b
    always_comb begin
        case (de_op)
            ALU_SUB: alu_res = de_a - de_b;
            ALU_AND: alu_res = de_a & de_b;
            ALU_OR:  alu_res = de_a | de_b;
            ALU_XOR: alu_res = de_a ^ de_b;
            ALU_SHL: alu_res = de_a << de_b[$clog2(`DATA_W)-1:0];
            ALU_SHR: alu_res = de_a >> de_b[$clog2(`DATA_W)-1:0];
            default: alu_res = de_a + de_b;
        endcase
    end

    // n from the sign bit, z on an all zero result
    assign alu_flags = {alu_res[`DATA_W-1], (alu_res == '0)};

    // selz looks at z as left by the previous flag setter
    always_comb begin
        case (de_sel)
            RES_IMM: result = de_imm;
            RES_SEL: result = flags[0] ? de_a : de_b;
            default: result = alu_res;
        endcase
    end

    ////////////////////////////////////////
    // flag register
    ////////////////////////////////////////

    // visible to the very next instruction in execute
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (de_valid && de_set_flags) begin
            flags <= alu_flags;
        end
    end

    ////////////////////////////////////////
    // execute to result register
    ////////////////////////////////////////

    // every accepted write retires, nop and cmp with wen low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            retire_wen   <= 1'b0;
        end else begin
            retire_valid <= de_valid;
            retire_wen   <= de_valid && de_wen;
        end
    end

    always_ff @(posedge clk) begin
        retire_rd   <= de_rd;
        retire_data <= result;
    end

endmodule

//--- isa_pkg.sv
`include "core_params.svh"

package isa_pkg;

    // one data or instruction word
    typedef logic [`DATA_W-1:0] word_t;

    // register index, wide enough for REG_COUNT
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    // bit 1 is N, bit 0 is Z
    typedef logic [1:0] flags_t;

    // opcode field, 12 to 15 left unassigned and decoded as nop
    typedef enum logic [`OPC_MSB-`OPC_LSB:0] {
        NOP  = 0,
        ADD  = 1,
        SUB  = 2,
        AND  = 3,
        OR   = 4,
        XOR  = 5,
        SHL  = 6,   // logical, by rs2[4:0]
        SHR  = 7,   // logical, by rs2[4:0]
        ADDI = 8,   // rs1 + sign extended imm
        LDI  = 9,   // sign extended imm
        CMP  = 10,  // rs1 - rs2, flags only
        SELZ = 11   // z ? rs1 : rs2
    } opcode_e;

endpackage

//--- result_stage.sv
`timescale 1ns/100ps
`include "core_params.svh"

module result_stage (
    input  logic                clk,
    input  logic                rst_n,
    // read ports from decode
    input  isa_pkg::reg_idx_t   rs1_idx,
    input  isa_pkg::reg_idx_t   rs2_idx,
    // retiring result from execute
    input  logic                retire_valid,
    input  logic                retire_wen,
    input  isa_pkg::reg_idx_t   retire_rd,
    input  isa_pkg::word_t      retire_data,
    output isa_pkg::word_t      rs1_data,
    output isa_pkg::word_t      rs2_data
);

    import isa_pkg::*;

    word_t regs [`REG_COUNT];
    logic  commit;

    // only real writes reach the array
    assign commit = retire_valid && retire_wen;

    // written at the edge that closes the retire cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (commit) begin
            regs[retire_rd] <= retire_data;
        end
    end

    ////////////////////////////////////////
    // read ports with bypass
    ////////////////////////////////////////

    // pending write wins over the stored value
    assign rs1_data = (commit && (retire_rd == rs1_idx)) ? retire_data : regs[rs1_idx];
    assign rs2_data = (commit && (retire_rd == rs2_idx)) ? retire_data : regs[rs2_idx];

endmodule

//--- tb_cpu_core.sv
`timescale 1ns/100ps
`include "core_params.svh"

module tb_cpu_core;

    import isa_pkg::*;

    localparam logic [31:0] SEED = 32'h9bd0f2d5;
    localparam int RAND_COUNT = 300;
    // reset regs, alu, forwarding, flags, bus, random stream
    localparam int INSTR_COUNT = 16 + 12 + 6 + 10 + 5 + RAND_COUNT;
    // a transfer never needs more than 4 cycles here
    localparam int TIMEOUT_CYCLES = INSTR_COUNT * 4 + 50;

    logic     clk;
    logic     rst_n;
    logic     cyc;
    logic     stb;
    logic     we;
    word_t    dat_w;
    logic     ack;
    logic     retire_valid;
    logic     retire_wen;
    reg_idx_t retire_rd;
    word_t    retire_data;
    flags_t   flags;

    // reference model state
    word_t  model_regs [`REG_COUNT];
    flags_t model_flags;

    // expected retires as {wen, rd, data, flags}
    logic [38:0] exp_q [$];
    string       name_q [$];
    int          errors = 0;
    int          checks = 0;

    cpu_core uut (
        .clk(clk),
        .rst_n(rst_n),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .dat_w(dat_w),
        .ack(ack),
        .retire_valid(retire_valid),
        .retire_wen(retire_wen),
        .retire_rd(retire_rd),
        .retire_data(retire_data),
        .flags(flags)
    );

    bind cpu_core cpu_core_properties props (
        .clk(clk),
        .rst_n(rst_n),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .ack(ack),
        .retire_valid(retire_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: no progress after %0d cycles, run stopped", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // reference model and helpers
    ////////////////////////////////////////

    function automatic word_t encode_instr(logic [3:0] op, int rd, int rs1, int rs2, int imm);
        return {op, rd[3:0], rs1[3:0], rs2[3:0], imm[15:0]};
    endfunction

    // runs one instruction through the model and returns the expected retire
    function automatic logic [38:0] model_exec(word_t instr);
        logic [3:0] op;
        reg_idx_t   rd;
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      res;
        logic       wen;
        logic       set_flags;
        op        = instr[`OPC_MSB:`OPC_LSB];
        rd        = instr[`RD_LSB +: 4];
        a         = model_regs[instr[`RS1_LSB +: 4]];
        b         = model_regs[instr[`RS2_LSB +: 4]];
        imm       = {{(`DATA_W-`IMM_W){instr[`IMM_W-1]}}, instr[`IMM_W-1:0]};
        res       = '0;
        wen       = 1'b1;
        set_flags = 1'b1;
        case (op)
            ADD:  res = a + b;
            SUB:  res = a - b;
            AND:  res = a & b;
            OR:   res = a | b;
            XOR:  res = a ^ b;
            SHL:  res = a << b[4:0];
            SHR:  res = a >> b[4:0];
            ADDI: res = a + imm;
            LDI: begin
                res       = imm;
                set_flags = 1'b0;
            end
            // flags only
            CMP: begin
                res = a - b;
                wen = 1'b0;
            end
            // z as left by the last flag setter
            SELZ: begin
                res       = model_flags[0] ? a : b;
                set_flags = 1'b0;
            end
            // nop and opcodes 12..15
            default: begin
                wen       = 1'b0;
                set_flags = 1'b0;
            end
        endcase
        if (set_flags) begin
            model_flags = {res[31], res == 32'd0};
        end
        if (wen) begin
            model_regs[rd] = res;
        end
        return {wen, rd, res, model_flags};
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // wishbone classic cycle entered and left on a falling edge
    task automatic bus_transfer(input logic write, input word_t word, input string name);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        dat_w = word;
        do begin
            @(negedge clk);
        end while (!ack);
        // taken at the last rising edge
        if (write) begin
            exp_q.push_back(model_exec(word));
            name_q.push_back(name);
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    // let everything in flight retire and idle a few cycles
    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    ////////////////////////////////////////
    // retire compare
    ////////////////////////////////////////

    // retire_valid spans exactly one falling edge
    always @(negedge clk) begin : compare_retire
        logic [38:0] entry;
        string       name;
        if (rst_n && retire_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR: an instruction retired at %0t with none outstanding", $time);
            end else begin
                entry = exp_q.pop_front();
                name  = name_q.pop_front();
                check_value({name, " wen"}, word_t'(entry[38]), word_t'(retire_wen));
                // rd and data mean nothing without a write
                if (entry[38]) begin
                    check_value({name, " rd"}, word_t'(entry[37:34]), word_t'(retire_rd));
                    check_value({name, " data"}, entry[33:2], retire_data);
                end
                check_value({name, " flags"}, word_t'(entry[1:0]), word_t'(flags));
            end
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin : main_sequence
        int    gap;
        word_t word;
        cyc         = 1'b0;
        stb         = 1'b0;
        we          = 1'b0;
        dat_w       = '0;
        rst_n       = 1'b0;
        model_flags = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        void'($urandom(SEED));
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // first cycle out of reset
        check_value("reset ack", '0, word_t'(ack));
        check_value("reset retire_valid", '0, word_t'(retire_valid));
        check_value("reset flags", '0, word_t'(flags));
        // every register should read back zero
        for (int i = 0; i < `REG_COUNT; i++) begin
            bus_transfer(1'b1, encode_instr(ADD, i, i, 0, 0), "reset regs");
        end

        // arithmetic and logic with negative immediates
        bus_transfer(1'b1, encode_instr(LDI, 1, 0, 0, 1234), "alu");
        bus_transfer(1'b1, encode_instr(LDI, 2, 0, 0, -5), "alu");
        bus_transfer(1'b1, encode_instr(LDI, 3, 0, 0, 3), "alu");
        bus_transfer(1'b1, encode_instr(ADD, 4, 1, 2, 0), "alu add");
        bus_transfer(1'b1, encode_instr(SUB, 5, 1, 2, 0), "alu sub");
        bus_transfer(1'b1, encode_instr(AND, 6, 1, 2, 0), "alu and");
        bus_transfer(1'b1, encode_instr(OR, 7, 1, 2, 0), "alu or");
        bus_transfer(1'b1, encode_instr(XOR, 8, 1, 2, 0), "alu xor");
        bus_transfer(1'b1, encode_instr(SHL, 9, 2, 3, 0), "alu shl");
        bus_transfer(1'b1, encode_instr(SHR, 10, 2, 3, 0), "alu shr");
        bus_transfer(1'b1, encode_instr(ADDI, 11, 1, 0, -2000), "alu addi");
        bus_transfer(1'b1, encode_instr(ADDI, 12, 2, 0, 5), "alu addi");

        // each one reads the rd of the one before
        bus_transfer(1'b1, encode_instr(LDI, 1, 0, 0, 10), "forwarding");
        bus_transfer(1'b1, encode_instr(ADD, 2, 1, 1, 0), "forwarding");
        bus_transfer(1'b1, encode_instr(ADD, 3, 2, 1, 0), "forwarding");
        bus_transfer(1'b1, encode_instr(SUB, 4, 2, 3, 0), "forwarding");
        bus_transfer(1'b1, encode_instr(ADDI, 5, 4, 0, -100), "forwarding");
        bus_transfer(1'b1, encode_instr(XOR, 6, 5, 4, 0), "forwarding");

        // cmp less then cmp equal, each followed by selz
        bus_transfer(1'b1, encode_instr(LDI, 1, 0, 0, 7), "flags");
        bus_transfer(1'b1, encode_instr(LDI, 2, 0, 0, 7), "flags");
        bus_transfer(1'b1, encode_instr(LDI, 4, 0, 0, 100), "flags");
        bus_transfer(1'b1, encode_instr(LDI, 5, 0, 0, 200), "flags");
        bus_transfer(1'b1, encode_instr(CMP, 0, 4, 5, 0), "flags cmp less");
        bus_transfer(1'b1, encode_instr(SELZ, 6, 4, 5, 0), "flags selz not z");
        // ldi in between must leave n set
        bus_transfer(1'b1, encode_instr(LDI, 7, 0, 0, 5), "flags ldi keeps");
        bus_transfer(1'b1, encode_instr(SELZ, 8, 4, 5, 0), "flags selz not z");
        bus_transfer(1'b1, encode_instr(CMP, 0, 1, 2, 0), "flags cmp equal");
        bus_transfer(1'b1, encode_instr(SELZ, 9, 4, 5, 0), "flags selz z");

        // a read is acked but must not retire
        drain();
        bus_transfer(1'b0, $urandom(), "read cycle");
        drain();

        // unused opcodes behave as nop
        for (int op = 12; op < 16; op++) begin
            word                    = $urandom();
            word[`OPC_MSB:`OPC_LSB] = op[3:0];
            bus_transfer(1'b1, word, "unused opcode");
        end

        // random words with random idle gaps
        repeat (RAND_COUNT) begin
            bus_transfer(1'b1, $urandom(), "random stream");
            gap = $urandom_range(3, 0);
            repeat (gap) @(negedge clk);
        end

        drain();
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, uut.props.assert_fails);
        if (errors == 0 && uut.props.assert_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
isa_pkg.sv
core_pkg.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
cpu_core.sv
cpu_core_properties.sv
tb_cpu_core.sv
